//--- source/nn_cfg_pkg.sv
`default_nettype none

package nn_cfg_pkg;

  localparam int LANES  = 8;                   // Lanes in one x vector
  localparam int LANE_W = 8;                   // Signed lane width
  localparam int X_W    = LANES * LANE_W;      // Whole x vector
  localparam int TRIT_W = 2;                   // One ternary weight
  localparam int ROW_W  = LANES * TRIT_W;      // One weight row
  localparam int ACC_W  = 16;                  // Accumulator, wraps

  localparam int ENTRY_ADDRS  = 64;                    // Entries per memory
  localparam int ENTRY_ADDR_W = $clog2(ENTRY_ADDRS);

  localparam int DATA_BRAM_W_DEF   = 16;       // Data RAM word, 4 pieces per x
  localparam int WEIGHT_BRAM_W_DEF = 8;        // Weight RAM word, 2 pieces per row
  localparam int OP_W              = 8;        // Instruction and its RAM word

  typedef logic signed [LANE_W-1:0] lane_t;
  typedef logic [X_W-1:0] x_vec_t;             // Lane 0 in the low byte
  typedef logic [ROW_W-1:0] trit_row_t;        // Trit i at bits 2i+1:2i
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [ENTRY_ADDR_W-1:0] entry_addr_t;

endpackage

`default_nettype wire

//--- source/nn_isa_pkg.sv
`default_nettype none

package nn_isa_pkg;

  localparam int OPERAND_W = nn_cfg_pkg::ENTRY_ADDR_W;  // Low field is an entry
  localparam int OPC_W     = nn_cfg_pkg::OP_W - OPERAND_W;
  localparam int OPC_LSB   = OPERAND_W;                 // Opcode sits on top

  typedef logic [nn_cfg_pkg::OP_W-1:0] instr_t;
  typedef logic [OPC_W-1:0] opcode_t;

  localparam opcode_t OP_LDX = 2'd0;           // Load x from data entry
  localparam opcode_t OP_DOT = 2'd1;           // acc = x . row
  localparam opcode_t OP_MAC = 2'd2;           // acc += x . row
  localparam opcode_t OP_OUT = 2'd3;           // Emit acc

  localparam logic [nn_cfg_pkg::TRIT_W-1:0] TRIT_POS = 2'b01;  // +1
  localparam logic [nn_cfg_pkg::TRIT_W-1:0] TRIT_NEG = 2'b11;  // -1, 00/10 are zero

  localparam int OUT_RELU_BIT = 0;             // Clamp negative result to 0
  localparam int OUT_LAST_BIT = 5;             // Halt after this emit

  typedef enum logic [2:0] {IDLE, FETCH, DECODE, READ, DOT_WAIT, EMIT} cpu_state_e;

endpackage

`default_nettype wire

//--- source/medium_if.sv
`timescale 1ns/10ps
`default_nettype none

// One CPU to memory reader link, W is the assembled entry width
interface medium_if #(
  parameter int W = 8
) ();

  nn_cfg_pkg::entry_addr_t addr;               // Entry index, valid with re
  logic                    re;                 // One-cycle read request
  logic [W-1:0]            data;               // Held from finished onward
  logic                    finished;           // One-cycle done pulse

  modport cpu (
    output addr, re,
    input  data, finished
  );

  modport reader (
    input  addr, re,
    output data, finished
  );

endinterface

`default_nettype wire

//--- source/block_ram.sv
`timescale 1ns/10ps
`default_nettype none

module block_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 64
) (
  input  wire logic                     clk_100mhz,
  input  wire logic                     arst_n,
  input  wire logic [$clog2(DEPTH)-1:0] wr_addr,    // Host side
  input  wire logic [WIDTH-1:0]         wr_data,
  input  wire logic                     wr_en,
  input  wire logic [$clog2(DEPTH)-1:0] rd_addr,    // Reader side
  input  wire logic                     rd_en,      // Output register enable
  output logic      [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] addr_q;                 // Registered read address

  always_ff @(posedge clk_100mhz) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    addr_q <= rd_addr;
  end

  // Read-first, a write on the same edge still returns the old word
  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[addr_q];
    end
  end

  wr_addr_in_range: assert property (
    @(posedge clk_100mhz) disable iff (!arst_n) wr_en |-> (wr_addr < DEPTH)
  );

endmodule

`default_nettype wire

//--- source/entry_reader.sv
`timescale 1ns/10ps
`default_nettype none

module entry_reader #(
  parameter int PIECES = 2,
  parameter int WIDTH  = 8
) (
  input  wire logic clk_100mhz,
  input  wire logic arst_n,
  medium_if.reader  med,
  output logic [$clog2(nn_cfg_pkg::ENTRY_ADDRS*PIECES)-1:0] rd_addr,
  output logic      rd_en,
  input  wire logic [WIDTH-1:0] rd_data
);

  localparam int AW = $clog2(nn_cfg_pkg::ENTRY_ADDRS * PIECES);
  localparam int CW = (PIECES > 1) ? $clog2(PIECES) : 1;
  localparam logic [CW-1:0] LAST = CW'(PIECES - 1);

  nn_cfg_pkg::entry_addr_t base_q;             // Entry being read
  nn_cfg_pkg::entry_addr_t entry;
  logic [CW-1:0]           cnt_q;              // Next piece to issue
  logic [CW-1:0]           piece;              // Piece issued this cycle
  logic [CW-1:0]           piece_d1;           // Piece in the RAM output stage
  logic [CW-1:0]           piece_d2;           // Piece now on rd_data
  logic                    issuing_q;
  logic                    open_q;             // Request accepted, not finished
  logic                    take;
  logic                    issue;
  logic                    cap_q;              // rd_data holds a piece
  logic                    fin_q;
  logic [PIECES*WIDTH-1:0] word_q;             // Assembled entry

  assign take  = med.re && !open_q;
  assign issue = take || issuing_q;
  assign piece = take ? '0 : cnt_q;            // Piece 0 goes out with re
  assign entry = take ? med.addr : base_q;
  assign rd_addr = AW'(entry) * AW'(PIECES) + AW'(piece);

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      open_q    <= 1'b0;
      issuing_q <= 1'b0;
      cnt_q     <= '0;
      rd_en     <= 1'b0;
      cap_q     <= 1'b0;
      fin_q     <= 1'b0;
    end else begin
      rd_en <= issue;                          // RAM output loads one cycle later
      cap_q <= rd_en;
      fin_q <= cap_q && (piece_d2 == LAST);    // Last piece lands with finished
      if (take) begin
        open_q    <= 1'b1;
        issuing_q <= (PIECES > 1);
        cnt_q     <= CW'(1);
      end else if (issuing_q) begin
        cnt_q <= cnt_q + CW'(1);
        if (cnt_q == LAST) begin
          issuing_q <= 1'b0;
        end
      end
      if (fin_q) begin
        open_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    base_q   <= entry;
    piece_d1 <= piece;
    piece_d2 <= piece_d1;
    if (cap_q) begin
      word_q[piece_d2*WIDTH +: WIDTH] <= rd_data;  // Piece 0 is least significant
    end
  end

  assign med.data     = word_q;
  assign med.finished = fin_q;

  no_re_while_open: assert property (
    @(posedge clk_100mhz) disable iff (!arst_n) med.re |-> !open_q
  );

endmodule

`default_nettype wire

//--- source/ternary_dot.sv
`timescale 1ns/10ps
`default_nettype none

module ternary_dot (
  input  wire logic                  clk_100mhz,
  input  wire logic                  arst_n,
  input  wire logic                  in_valid,
  input  wire nn_cfg_pkg::x_vec_t    x,
  input  wire nn_cfg_pkg::trit_row_t row,
  output nn_cfg_pkg::acc_t           sum,
  output logic                       out_valid
);

  nn_cfg_pkg::acc_t sum_d;

  // Each trit picks +x, -x or nothing for its lane
  always_comb begin
    nn_cfg_pkg::lane_t                 lane;
    logic [nn_cfg_pkg::TRIT_W-1:0]     trit;
    sum_d = '0;
    for (int i = 0; i < nn_cfg_pkg::LANES; i++) begin
      lane = x[i*nn_cfg_pkg::LANE_W +: nn_cfg_pkg::LANE_W];
      trit = row[i*nn_cfg_pkg::TRIT_W +: nn_cfg_pkg::TRIT_W];
      if (trit == nn_isa_pkg::TRIT_POS) begin
        sum_d = sum_d + nn_cfg_pkg::acc_t'(lane);   // Sign extended first
      end else if (trit == nn_isa_pkg::TRIT_NEG) begin
        sum_d = sum_d - nn_cfg_pkg::acc_t'(lane);
      end
    end
  end

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    sum <= sum_d;                              // Wraps at ACC_W
  end

endmodule

`default_nettype wire

//--- source/inference_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module inference_cpu (
  input  wire logic                  clk_100mhz,
  input  wire logic                  arst_n,
  input  wire logic                  start,
  output logic                       busy,
  medium_if.cpu                      op_m,
  medium_if.cpu                      data_m,
  medium_if.cpu                      weight_m,
  output logic                       dot_valid,
  output nn_cfg_pkg::x_vec_t         dot_x,
  output nn_cfg_pkg::trit_row_t      dot_row,
  input  wire nn_cfg_pkg::acc_t      dot_sum,
  input  wire logic                  dot_done,
  output nn_cfg_pkg::acc_t           inference_out,
  output logic                       inference_valid
);

  nn_isa_pkg::cpu_state_e  state_q;
  nn_isa_pkg::instr_t      instr;
  nn_isa_pkg::opcode_t     opcode;
  nn_cfg_pkg::entry_addr_t operand;
  nn_cfg_pkg::entry_addr_t pc_q;
  nn_cfg_pkg::x_vec_t      x_q;
  nn_cfg_pkg::acc_t        acc_q;
  nn_cfg_pkg::acc_t        out_val;
  logic                    op_re_q;
  logic                    data_re_q;
  logic                    weight_re_q;
  logic                    relu_flag;
  logic                    last_flag;
  logic                    x_load;           // LDX data arrived
  logic                    acc_load;         // Dot result arrived
  logic                    emit;
  logic                    step;             // Go fetch pc+1

  // Instruction stays on op_m.data until the next fetch finishes
  assign instr     = op_m.data;
  assign opcode    = instr[nn_isa_pkg::OPC_LSB +: nn_isa_pkg::OPC_W];
  assign operand   = instr[nn_isa_pkg::OPERAND_W-1:0];
  assign relu_flag = operand[nn_isa_pkg::OUT_RELU_BIT];
  assign last_flag = operand[nn_isa_pkg::OUT_LAST_BIT];

  assign x_load   = (state_q == nn_isa_pkg::READ) && data_m.finished;
  assign acc_load = (state_q == nn_isa_pkg::DOT_WAIT) && dot_done;
  assign emit     = (state_q == nn_isa_pkg::EMIT);
  assign step     = x_load || acc_load || (emit && !last_flag);

  assign busy = (state_q != nn_isa_pkg::IDLE);
  assign out_val = (relu_flag && acc_q[nn_cfg_pkg::ACC_W-1]) ? '0 : acc_q;  // ReLU

  assign op_m.addr     = pc_q;
  assign op_m.re       = op_re_q;
  assign data_m.addr   = operand;            // Only sampled with re
  assign data_m.re     = data_re_q;
  assign weight_m.addr = operand;
  assign weight_m.re   = weight_re_q;
  assign dot_x         = x_q;
  assign dot_row       = weight_m.data;      // Held while the dot runs

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      state_q         <= nn_isa_pkg::IDLE;
      pc_q            <= '0;
      op_re_q         <= 1'b0;
      data_re_q       <= 1'b0;
      weight_re_q     <= 1'b0;
      dot_valid       <= 1'b0;
      inference_valid <= 1'b0;
    end else begin
      op_re_q         <= 1'b0;               // All requests are single pulses
      data_re_q       <= 1'b0;
      weight_re_q     <= 1'b0;
      dot_valid       <= 1'b0;
      inference_valid <= emit;
      case (state_q)
        nn_isa_pkg::IDLE: begin
          if (start) begin
            pc_q    <= '0;
            op_re_q <= 1'b1;
            state_q <= nn_isa_pkg::FETCH;
          end
        end
        nn_isa_pkg::FETCH: begin
          if (op_m.finished) begin
            state_q <= nn_isa_pkg::DECODE;
          end
        end
        nn_isa_pkg::DECODE: begin
          if (opcode == nn_isa_pkg::OP_OUT) begin
            state_q <= nn_isa_pkg::EMIT;
          end else begin
            data_re_q   <= (opcode == nn_isa_pkg::OP_LDX);
            weight_re_q <= (opcode != nn_isa_pkg::OP_LDX);  // DOT or MAC
            state_q     <= nn_isa_pkg::READ;
          end
        end
        nn_isa_pkg::READ: begin
          if (weight_m.finished) begin
            dot_valid <= 1'b1;
            state_q   <= nn_isa_pkg::DOT_WAIT;
          end
        end
        nn_isa_pkg::EMIT: begin
          if (last_flag) begin
            state_q <= nn_isa_pkg::IDLE;     // busy drops next cycle
          end
        end
        default: ;                           // DOT_WAIT leaves through step
      endcase
      if (step) begin
        pc_q    <= pc_q + 1'b1;
        op_re_q <= 1'b1;
        state_q <= nn_isa_pkg::FETCH;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (x_load) begin
      x_q <= data_m.data;
    end
    if (acc_load) begin
      acc_q <= (opcode == nn_isa_pkg::OP_MAC) ? acc_q + dot_sum : dot_sum;  // Wraps
    end
    if (emit) begin
      inference_out <= out_val;
    end
  end

  // Program must halt before running off the end of op memory
  pc_no_wrap: assert property (
    @(posedge clk_100mhz) disable iff (!arst_n) busy && $past(busy) |-> pc_q >= $past(pc_q)
  );

endmodule

`default_nettype wire

//--- source/nn_top.sv
`timescale 1ns/10ps
`default_nettype none

module nn_top #(
  parameter int DATA_BRAM_W   = nn_cfg_pkg::DATA_BRAM_W_DEF,
  parameter int WEIGHT_BRAM_W = nn_cfg_pkg::WEIGHT_BRAM_W_DEF,
  localparam int DATA_PIECES   = nn_cfg_pkg::X_W / DATA_BRAM_W,
  localparam int WEIGHT_PIECES = nn_cfg_pkg::ROW_W / WEIGHT_BRAM_W,
  localparam int OP_PIECES     = 1,          // One instruction per RAM word
  localparam int DATA_DEPTH    = nn_cfg_pkg::ENTRY_ADDRS * DATA_PIECES,
  localparam int WEIGHT_DEPTH  = nn_cfg_pkg::ENTRY_ADDRS * WEIGHT_PIECES,
  localparam int OP_DEPTH      = nn_cfg_pkg::ENTRY_ADDRS * OP_PIECES
) (
  input  wire logic                        clk_100mhz,
  input  wire logic                        arst_n,
  input  wire logic [$clog2(OP_DEPTH)-1:0] op_addr,      // Host load, instructions
  input  wire logic [nn_cfg_pkg::OP_W-1:0] op_din,
  input  wire logic                        op_we,
  input  wire logic [$clog2(DATA_DEPTH)-1:0] data_addr,  // Host load, x vectors
  input  wire logic [DATA_BRAM_W-1:0]      data_din,
  input  wire logic                        data_we,
  input  wire logic [$clog2(WEIGHT_DEPTH)-1:0] weight_addr,  // Host load, rows
  input  wire logic [WEIGHT_BRAM_W-1:0]    weight_din,
  input  wire logic                        weight_we,
  input  wire logic                        start,
  output nn_cfg_pkg::acc_t                 inference_out,
  output logic                             inference_valid,
  output logic                             busy
);

  logic [$clog2(OP_DEPTH)-1:0]     op_rd_addr;
  logic                            op_rd_en;
  logic [nn_cfg_pkg::OP_W-1:0]     op_rd_data;
  logic [$clog2(DATA_DEPTH)-1:0]   data_rd_addr;
  logic                            data_rd_en;
  logic [DATA_BRAM_W-1:0]          data_rd_data;
  logic [$clog2(WEIGHT_DEPTH)-1:0] weight_rd_addr;
  logic                            weight_rd_en;
  logic [WEIGHT_BRAM_W-1:0]        weight_rd_data;

  logic                  dot_valid;
  nn_cfg_pkg::x_vec_t    dot_x;
  nn_cfg_pkg::trit_row_t dot_row;
  nn_cfg_pkg::acc_t      dot_sum;
  logic                  dot_done;

  medium_if #(.W(nn_cfg_pkg::OP_W))  op_m ();
  medium_if #(.W(nn_cfg_pkg::X_W))   data_m ();
  medium_if #(.W(nn_cfg_pkg::ROW_W)) weight_m ();

  block_ram #(.WIDTH(nn_cfg_pkg::OP_W), .DEPTH(OP_DEPTH)) op_bram (
    .clk_100mhz, .arst_n,
    .wr_addr(op_addr), .wr_data(op_din), .wr_en(op_we),
    .rd_addr(op_rd_addr), .rd_en(op_rd_en), .rd_data(op_rd_data)
  );

  block_ram #(.WIDTH(DATA_BRAM_W), .DEPTH(DATA_DEPTH)) data_bram (
    .clk_100mhz, .arst_n,
    .wr_addr(data_addr), .wr_data(data_din), .wr_en(data_we),
    .rd_addr(data_rd_addr), .rd_en(data_rd_en), .rd_data(data_rd_data)
  );

  block_ram #(.WIDTH(WEIGHT_BRAM_W), .DEPTH(WEIGHT_DEPTH)) weight_bram (
    .clk_100mhz, .arst_n,
    .wr_addr(weight_addr), .wr_data(weight_din), .wr_en(weight_we),
    .rd_addr(weight_rd_addr), .rd_en(weight_rd_en), .rd_data(weight_rd_data)
  );

  entry_reader #(.PIECES(OP_PIECES), .WIDTH(nn_cfg_pkg::OP_W)) op_reader (
    .clk_100mhz, .arst_n, .med(op_m),
    .rd_addr(op_rd_addr), .rd_en(op_rd_en), .rd_data(op_rd_data)
  );

  entry_reader #(.PIECES(DATA_PIECES), .WIDTH(DATA_BRAM_W)) data_reader (
    .clk_100mhz, .arst_n, .med(data_m),
    .rd_addr(data_rd_addr), .rd_en(data_rd_en), .rd_data(data_rd_data)
  );

  entry_reader #(.PIECES(WEIGHT_PIECES), .WIDTH(WEIGHT_BRAM_W)) weight_reader (
    .clk_100mhz, .arst_n, .med(weight_m),
    .rd_addr(weight_rd_addr), .rd_en(weight_rd_en), .rd_data(weight_rd_data)
  );

  ternary_dot dot_i (
    .clk_100mhz, .arst_n,
    .in_valid(dot_valid), .x(dot_x), .row(dot_row),
    .sum(dot_sum), .out_valid(dot_done)
  );

  inference_cpu cpu_i (
    .clk_100mhz, .arst_n, .start, .busy,
    .op_m(op_m), .data_m(data_m), .weight_m(weight_m),
    .dot_valid, .dot_x, .dot_row, .dot_sum, .dot_done,
    .inference_out, .inference_valid
  );

endmodule

`default_nettype wire

//--- tests/nn_tb_tasks.svh
`ifndef NN_TB_TASKS_SVH
`define NN_TB_TASKS_SVH

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic nn_cfg_pkg::x_vec_t rand_x();
    nn_cfg_pkg::x_vec_t x;
    for (int i = 0; i < nn_cfg_pkg::LANES; i++) begin
      x[i*8 +: 8] = 8'(rand_bits(8));
    end
    return x;
  endfunction

  function automatic nn_cfg_pkg::trit_row_t rand_row();
    nn_cfg_pkg::trit_row_t row;
    for (int i = 0; i < nn_cfg_pkg::LANES; i++) begin
      row[2*i +: 2] = 2'(rand_bits(2));                         // All four codes occur
    end
    return row;
  endfunction

  // Expected dot where 01 adds the lane, 11 subtracts it and 00 or 10 skip it
  function automatic nn_cfg_pkg::acc_t model_dot(input nn_cfg_pkg::x_vec_t x,
                                                 input nn_cfg_pkg::trit_row_t row);
    int total;
    int lane;
    total = 0;
    for (int i = 0; i < nn_cfg_pkg::LANES; i++) begin
      lane = int'($signed(x[i*8 +: 8]));
      case (row[2*i +: 2])
        2'b01:   total = total + lane;
        2'b11:   total = total - lane;
        default: ;
      endcase
    end
    return nn_cfg_pkg::acc_t'(total);                          // Keep the low 16 bits
  endfunction

  function automatic nn_cfg_pkg::acc_t model_relu(input nn_cfg_pkg::acc_t v);
    if (v < 0) begin
      return '0;
    end
    return v;
  endfunction

  function automatic nn_isa_pkg::instr_t make_instr(input nn_isa_pkg::opcode_t op,
                                                    input int operand);
    return {op, nn_cfg_pkg::entry_addr_t'(operand)};            // Opcode in the top 2 bits
  endfunction

  function automatic int out_flags(input logic relu, input logic last);
    return (int'(last) << nn_isa_pkg::OUT_LAST_BIT) | (int'(relu) << nn_isa_pkg::OUT_RELU_BIT);
  endfunction

  task automatic check_acc(input string name, input nn_cfg_pkg::acc_t got,
                           input nn_cfg_pkg::acc_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic expect_result(input int idx, input nn_cfg_pkg::acc_t exp);
    if (idx >= results.size()) begin
      check_count++;
      err_count++;
      $display("No inference result number %0d arrived by %0t", idx, $time);
    end else begin
      check_acc("inference_out", results[idx], exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic load_instr(input int entry, input nn_isa_pkg::instr_t ins);
    @(posedge clk);
    #DRIVE_DLY;
    op_addr = nn_cfg_pkg::entry_addr_t'(entry);                 // One word per instruction
    op_din  = ins;
    op_we   = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    op_we   = 1'b0;
  endtask

  task automatic load_x(input int entry, input nn_cfg_pkg::x_vec_t x);
    for (int p = 0; p < DATA_PIECES; p++) begin
      @(posedge clk);
      #DRIVE_DLY;
      data_addr = DATA_AW'(entry * DATA_PIECES + p);
      data_din  = x[p*DATA_W +: DATA_W];                        // Piece 0 holds lanes 0 and 1
      data_we   = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DLY;
    data_we = 1'b0;
  endtask

  task automatic load_row(input int entry, input nn_cfg_pkg::trit_row_t row);
    for (int p = 0; p < WEIGHT_PIECES; p++) begin
      @(posedge clk);
      #DRIVE_DLY;
      weight_addr = WEIGHT_AW'(entry * WEIGHT_PIECES + p);
      weight_din  = row[p*WEIGHT_W +: WEIGHT_W];
      weight_we   = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DLY;
    weight_we = 1'b0;
  endtask

  // Pulses start and waits for busy to fall
  // A nonzero restart_after adds a start pulse while busy
  task automatic run_program(input int restart_after, output int first);
    first = results.size();
    @(posedge clk);
    #DRIVE_DLY start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY start = 1'b0;
    @(negedge clk);
    check_bit("busy", busy, 1'b1);
    if (restart_after > 0) begin
      repeat (restart_after) @(posedge clk);
      #DRIVE_DLY start = 1'b1;
      check_bit("busy", busy, 1'b1);                            // Pulse lands mid-program
      @(posedge clk);
      #DRIVE_DLY start = 1'b0;
    end
    while (busy) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);                                  // Last result is queued by now
  endtask

  task automatic test_idle_after_reset();
    int errs;
    errs = err_count;
    @(negedge clk);
    for (int i = 0; i < 20; i++) begin
      check_bit("busy", busy, 1'b0);
      check_bit("inference_valid", inference_valid, 1'b0);
      @(negedge clk);
    end
    report_test("idle after reset", errs);
  endtask

  task automatic test_single_dot();
    nn_cfg_pkg::x_vec_t    x;
    nn_cfg_pkg::trit_row_t row;
    int                    first;
    int                    errs;
    errs = err_count;
    x    = rand_x();
    row  = rand_row();
    load_x(2, x);
    load_row(7, row);
    load_instr(0, make_instr(nn_isa_pkg::OP_LDX, 2));
    load_instr(1, make_instr(nn_isa_pkg::OP_DOT, 7));
    load_instr(2, make_instr(nn_isa_pkg::OP_OUT, out_flags(1'b0, 1'b1)));
    run_program(0, first);
    out_count += 1;
    check_acc("result count", nn_cfg_pkg::acc_t'(results.size() - first), 16'sd1);
    expect_result(first, model_dot(x, row));
    check_bit("busy", busy, 1'b0);
    report_test("single dot", errs);
  endtask

  task automatic test_mac_chain();
    nn_cfg_pkg::x_vec_t    x;
    nn_cfg_pkg::trit_row_t rows [3];
    nn_cfg_pkg::acc_t      exp;
    int                    first;
    int                    errs;
    errs = err_count;
    x    = rand_x();
    load_x(3, x);
    exp = '0;
    for (int r = 0; r < 3; r++) begin
      rows[r] = rand_row();
      load_row(10 + r, rows[r]);
      exp = exp + model_dot(x, rows[r]);                        // Sum wraps at 16 bits
    end
    load_instr(0, make_instr(nn_isa_pkg::OP_LDX, 3));
    load_instr(1, make_instr(nn_isa_pkg::OP_DOT, 10));
    load_instr(2, make_instr(nn_isa_pkg::OP_MAC, 11));
    load_instr(3, make_instr(nn_isa_pkg::OP_MAC, 12));
    load_instr(4, make_instr(nn_isa_pkg::OP_OUT, out_flags(1'b0, 1'b1)));
    run_program(0, first);
    out_count += 1;
    check_acc("result count", nn_cfg_pkg::acc_t'(results.size() - first), 16'sd1);
    expect_result(first, exp);
    report_test("mac chain", errs);
  endtask

  task automatic test_relu();
    nn_cfg_pkg::x_vec_t    x;
    nn_cfg_pkg::trit_row_t row;
    nn_cfg_pkg::acc_t      raw;
    int                    first;
    int                    errs;
    errs = err_count;
    x    = rand_x();
    x[7:0] = x[7:0] | 8'h01;                                    // At least one nonzero lane
    for (int i = 0; i < nn_cfg_pkg::LANES; i++) begin
      if ($signed(x[i*8 +: 8]) < 0) begin
        row[2*i +: 2] = 2'b01;                                  // Add a negative lane
      end else if (x[i*8 +: 8] != 8'h00) begin
        row[2*i +: 2] = 2'b11;                                  // Subtract a positive lane
      end else begin
        row[2*i +: 2] = 2'b00;
      end
    end
    raw = model_dot(x, row);
    load_x(4, x);
    load_row(13, row);
    load_instr(0, make_instr(nn_isa_pkg::OP_LDX, 4));
    load_instr(1, make_instr(nn_isa_pkg::OP_DOT, 13));
    load_instr(2, make_instr(nn_isa_pkg::OP_OUT, out_flags(1'b1, 1'b0)));
    load_instr(3, make_instr(nn_isa_pkg::OP_OUT, out_flags(1'b0, 1'b1)));
    run_program(0, first);
    out_count += 2;
    check_acc("result count", nn_cfg_pkg::acc_t'(results.size() - first), 16'sd2);
    expect_result(first, model_relu(raw));
    expect_result(first + 1, raw);
    report_test("relu", errs);
  endtask

  task automatic test_rerun();
    nn_cfg_pkg::x_vec_t    x;
    nn_cfg_pkg::trit_row_t row;
    int                    first;
    int                    errs;
    errs = err_count;
    x    = rand_x();
    row  = rand_row();
    load_x(5, x);
    load_row(20, row);
    load_instr(0, make_instr(nn_isa_pkg::OP_LDX, 5));
    load_instr(1, make_instr(nn_isa_pkg::OP_DOT, 20));
    load_instr(2, make_instr(nn_isa_pkg::OP_OUT, out_flags(1'b0, 1'b1)));
    run_program(0, first);
    out_count += 1;
    expect_result(first, model_dot(x, row));
    x = rand_x();
    load_x(5, x);                                               // Same program, new input
    run_program(5, first);
    out_count += 1;
    check_acc("result count", nn_cfg_pkg::acc_t'(results.size() - first), 16'sd1);
    expect_result(first, model_dot(x, row));
    repeat (10) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);                            // Ignored start left no run
    end
    check_acc("inference_valid pulses", nn_cfg_pkg::acc_t'(valid_count),
              nn_cfg_pkg::acc_t'(out_count));
    report_test("rerun", errs);
  endtask

`endif

//--- tests/nn_tb.sv
`timescale 1ns/10ps
`default_nettype none

module nn_tb;

  localparam int DATA_W        = nn_cfg_pkg::DATA_BRAM_W_DEF;
  localparam int WEIGHT_W      = nn_cfg_pkg::WEIGHT_BRAM_W_DEF;
  localparam int DATA_PIECES   = nn_cfg_pkg::X_W / DATA_W;        // 4 words per x
  localparam int WEIGHT_PIECES = nn_cfg_pkg::ROW_W / WEIGHT_W;    // 2 words per row
  localparam int DATA_AW       = $clog2(nn_cfg_pkg::ENTRY_ADDRS * DATA_PIECES);
  localparam int WEIGHT_AW     = $clog2(nn_cfg_pkg::ENTRY_ADDRS * WEIGHT_PIECES);
  localparam int DRIVE_DLY     = 1;                               // ns after the rising edge

  // Run length, tests 2 to 5 execute 18 instructions and write 47 RAM words
  localparam int INSTR_CYCLES = 10;
  localparam int TEST_INSTRS  = 18;
  localparam int LOAD_WORDS   = 47;
  localparam int IDLE_CYCLES  = 4 + 20 + 50;                      // Reset, idle test, settling
  localparam int CYCLE_LIMIT  =
    2 * (TEST_INSTRS * INSTR_CYCLES + 2 * LOAD_WORDS + IDLE_CYCLES);

  logic                            clk;
  logic                            arst_n;
  logic [nn_cfg_pkg::ENTRY_ADDR_W-1:0] op_addr;
  logic [nn_cfg_pkg::OP_W-1:0]     op_din;
  logic                            op_we;
  logic [DATA_AW-1:0]              data_addr;
  logic [DATA_W-1:0]               data_din;
  logic                            data_we;
  logic [WEIGHT_AW-1:0]            weight_addr;
  logic [WEIGHT_W-1:0]             weight_din;
  logic                            weight_we;
  logic                            start;
  nn_cfg_pkg::acc_t                inference_out;
  logic                            inference_valid;
  logic                            busy;

  logic [15:0]                     lfsr_q;                        // Stimulus LFSR state
  int                              err_count;
  int                              check_count;
  int                              out_count;                     // OUTs the tests ran
  int                              valid_count = 0;               // Every inference_valid seen
  int                              cycles;
  nn_cfg_pkg::acc_t                results[$];                    // Emitted values in order

  nn_top #(
    .DATA_BRAM_W  (DATA_W),
    .WEIGHT_BRAM_W(WEIGHT_W)
  ) dut_i (
    .clk_100mhz     (clk),
    .arst_n         (arst_n),
    .op_addr        (op_addr),
    .op_din         (op_din),
    .op_we          (op_we),
    .data_addr      (data_addr),
    .data_din       (data_din),
    .data_we        (data_we),
    .weight_addr    (weight_addr),
    .weight_din     (weight_din),
    .weight_we      (weight_we),
    .start          (start),
    .inference_out  (inference_out),
    .inference_valid(inference_valid),
    .busy           (busy)
  );

`include "nn_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;                                             // 100 ns period
    end
  end

  // Results are sampled half a cycle away from the edge that makes them
  always @(negedge clk) begin
    if (arst_n && inference_valid) begin
      results.push_back(inference_out);
      valid_count++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    lfsr_q      = 16'd9662;
    err_count   = 0;
    check_count = 0;
    out_count   = 0;
    arst_n      = 1'b0;
    op_addr     = '0;
    op_din      = '0;
    op_we       = 1'b0;
    data_addr   = '0;
    data_din    = '0;
    data_we     = 1'b0;
    weight_addr = '0;
    weight_din  = '0;
    weight_we   = 1'b0;
    start       = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY arst_n = 1'b1;
    test_idle_after_reset();
    test_single_dot();
    test_mac_chain();
    test_relu();
    test_rerun();
    $display("tests 5, checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+tests
source/nn_cfg_pkg.sv
source/nn_isa_pkg.sv
source/medium_if.sv
source/block_ram.sv
source/entry_reader.sv
source/ternary_dot.sv
source/inference_cpu.sv
source/nn_top.sv
tests/nn_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module nn_tb

# A crash or an assertion stop also counts as a failed run
obj_dir/Vnn_tb > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
